/* Bender.yml */
package:
  name: dp_lane_bridge

sources:
  - src/dp_bridge_pkg.sv
  - src/dp_apb_if.sv
  - src/dp_reset_gen.sv
  - src/dp_pio_regs.sv
  - src/dp_lane_map.sv
  - src/dp_heartbeat.sv
  - src/dp_lane_bridge_top.sv
  - target: test
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_dp_lane_bridge.sv

/* all.f */
src/dp_bridge_pkg.sv
src/dp_apb_if.sv
src/dp_reset_gen.sv
src/dp_pio_regs.sv
src/dp_lane_map.sv
src/dp_heartbeat.sv
src/dp_lane_bridge_top.sv
sim/tb_clk_gen.sv
sim/tb_dp_lane_bridge.sv

/* sim/tb_clk_gen.sv */
/*
    Testbench clock source
*/

`timescale 1ns/1ps

module tb_clk_gen
#(
    parameter real PERIOD_NS = 20.0
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

/* sim/tb_dp_lane_bridge.sv */
/*
    Testbench for the DP lane bridge top level
    APB tasks, LCG lane stimulus, reset, register, error, reorder and heartbeat checks
*/

`timescale 1ns/1ps

module tb_dp_lane_bridge import dp_bridge_pkg::*; ();

    localparam int HB_TB      = 16;
    localparam int WAIT_LIMIT = 2000;   // Longer than the reset sequence

    logic                  clk;
    logic                  arst_n;
    logic                  pll_lock;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
    logic [PIO_IN_W-1:0]   phy_status;
    logic [PIO_OUT_W-1:0]  phy_ctrl;
    tx_lane_t              dptx_lanes   [LANES];
    tx_lane_t              phy_tx_lanes [LANES];
    rx_lane_t              phy_rx_lanes [LANES];
    rx_lane_t              dprx_lanes   [LANES];
    logic [1:0]            led_out;

    logic [31:0] lcg_state   = 32'h8fd29eb5;
    int          errors      = 0;
    int          test_errors = 0;   // Error count when the current test began
    int          tests_done  = 0;

    tb_clk_gen #(.PERIOD_NS(20.0)) clk_gen_inst (.clk(clk));

    dp_lane_bridge_top #(.HB_CYCLES(HB_TB)) dp_lane_bridge_top_inst
    (
        .CLK_IN  (clk),
        .LED_OUT (led_out),
        .*
    );

    // Zero wait states and ready LED only with lock
    assert property (@(posedge clk) disable iff (!arst_n) pready)
        else report_error("pready went low");
    assert property (@(posedge clk) led_out[1] |-> pll_lock)
        else report_error("LED_OUT[1] high while PLL lock is low");

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic report_error(input string what);
        $display("Error at %0t: %s", $time, what);
        errors++;
    endtask

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        assert (got === exp)
        else
        begin
            $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_done++;
        $display("Test %0d %s: %s", tests_done, name, (errors == test_errors) ? "ok" : "failed");
        test_errors = errors;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;     // Drive point
    endtask

    // Counts edges until the LED bit reaches level
    task automatic wait_led(input int idx, input logic level, output int cycles);
        cycles = 0;
        while (led_out[idx] !== level && cycles < WAIT_LIMIT)
        begin
            next_cycle();
            cycles++;
        end
        if (led_out[idx] !== level)
            report_error($sformatf("timed out waiting for LED_OUT[%0d]", idx));
    endtask

    // Setup phase then access phase until pready
    task automatic apb_xfer(input logic write, input logic [APB_ADDR_W-1:0] addr,
                            input logic [APB_DATA_W-1:0] wdata,
                            output logic [APB_DATA_W-1:0] rdata, output logic err);
        int tries;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        next_cycle();
        penable = 1'b1;
        #1;
        tries = 0;
        while (pready !== 1'b1 && tries < WAIT_LIMIT)
        begin
            next_cycle();
            #1;
            tries++;
        end
        if (pready !== 1'b1)
            report_error("APB transfer never completed");
        rdata = prdata;
        err   = pslverr;
        next_cycle();   // Past the completing edge
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // Random words into both maps with outputs checked one clock later
    task automatic run_lanes(input int words, input bit tx_zero, input bit rx_zero);
        tx_lane_t    tx_sent [LANES];
        rx_lane_t    rx_sent [LANES];
        logic [31:0] r;
        for (int n = 0; n < words; n++)
        begin
            for (int i = 0; i < LANES; i++)
            begin
                r = lcg_next();
                dptx_lanes[i] = r[$bits(tx_lane_t)-1:0];
                r = lcg_next();
                phy_rx_lanes[i] = r[$bits(rx_lane_t)-1:0];
            end
            tx_sent = dptx_lanes;
            rx_sent = phy_rx_lanes;
            next_cycle();
            for (int i = 0; i < LANES; i++)
            begin
                check_val($sformatf("phy_tx_lanes[%0d]", i), 64'(phy_tx_lanes[i]),
                          tx_zero ? 64'd0 : 64'(tx_sent[TX_LANE_ORDER[i]]));
                check_val($sformatf("dprx_lanes[%0d]", i), 64'(dprx_lanes[i]),
                          rx_zero ? 64'd0 : 64'(rx_sent[RX_LANE_ORDER[i]]));
            end
        end
    endtask

    initial
    begin
        logic [APB_DATA_W-1:0] rd;
        logic                  err;
        int                    cycles;
        arst_n     = 1'b0;
        pll_lock   = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        phy_status = '0;
        for (int i = 0; i < LANES; i++)
        begin
            dptx_lanes[i]   = '1;   // Nonzero while the maps are held
            phy_rx_lanes[i] = '1;
        end
        repeat (8) next_cycle();

        check_val("phy_ctrl", 64'(phy_ctrl), 64'(CTRL_RESET));
        check_val("LED_OUT", 64'(led_out), 64'd0);
        for (int i = 0; i < LANES; i++)
        begin
            check_val("phy_tx_lanes", 64'(phy_tx_lanes[i]), 64'd0);
            check_val("dprx_lanes", 64'(dprx_lanes[i]), 64'd0);
        end
        arst_n = 1'b1;
        next_cycle();
        pll_lock = 1'b1;
        wait_led(1, 1'b1, cycles);
        check_val("LED_OUT[1] release cycles", 64'(cycles), 64'(RST_CYCLES));
        pll_lock = 1'b0;
        #1;
        check_val("LED_OUT[1]", 64'(led_out[1]), 64'd0);   // Cleared without a clock
        next_cycle();
        pll_lock = 1'b1;
        wait_led(1, 1'b1, cycles);
        check_val("LED_OUT[1] release cycles", 64'(cycles), 64'(RST_CYCLES));
        end_test("reset");

        apb_xfer(1'b1, REG_CTRL, 32'h5A, rd, err);
        check_val("pslverr", 64'(err), 64'd0);
        check_val("phy_ctrl", 64'(phy_ctrl), 64'h5A);
        apb_xfer(1'b0, REG_CTRL, '0, rd, err);
        check_val("prdata", 64'(rd), 64'h5A);
        for (int k = 0; k < 2; k++)
        begin
            phy_status = (k == 0) ? 7'h35 : 7'h4A;
            repeat (2) next_cycle();    // Synchronizer depth
            apb_xfer(1'b0, REG_STATUS, '0, rd, err);
            check_val("prdata", 64'(rd), 64'(phy_status));
        end
        apb_xfer(1'b0, REG_VERSION, '0, rd, err);
        check_val("prdata", 64'(rd), 64'h0100);
        end_test("registers");

        apb_xfer(1'b0, 8'h0C, '0, rd, err);
        check_val("pslverr", 64'(err), 64'd1);
        apb_xfer(1'b1, 8'h0C, 32'hFF, rd, err);
        check_val("pslverr", 64'(err), 64'd1);
        check_val("phy_ctrl", 64'(phy_ctrl), 64'h5A);
        apb_xfer(1'b1, REG_STATUS, 32'h00, rd, err);
        check_val("pslverr", 64'(err), 64'd1);
        check_val("phy_ctrl", 64'(phy_ctrl), 64'h5A);
        end_test("errors");

        // TX running while RX is held in digital reset
        apb_xfer(1'b1, REG_CTRL, 32'hDA, rd, err);
        run_lanes(100, 1'b0, 1'b1);
        end_test("tx reorder");

        // RX running while TX is held in digital reset
        apb_xfer(1'b1, REG_CTRL, 32'h7A, rd, err);
        run_lanes(100, 1'b1, 1'b0);
        end_test("rx reorder");

        wait_led(0, ~led_out[0], cycles);   // Align to a toggle
        for (int k = 0; k < 3; k++)
        begin
            wait_led(0, ~led_out[0], cycles);
            check_val("LED_OUT[0] toggle cycles", 64'(cycles), 64'(HB_TB));
        end
        end_test("heartbeat");

        $display("Tests run: %0d, errors: %0d", tests_done, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* src/dp_apb_if.sv */
/*
    APB bus between the top level and the PIO register block
    Master and slave modports
*/

`timescale 1ns/1ps

interface dp_apb_if import dp_bridge_pkg::*; ();

    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;

    // Requester side
    modport master
    (
        output psel, penable, pwrite, paddr, pwdata,
        input  prdata, pready, pslverr
    );

    modport slave
    (
        input  psel, penable, pwrite, paddr, pwdata,
        output prdata, pready, pslverr
    );

endinterface

/* src/dp_bridge_pkg.sv */
/*
    Shared definitions for the DP lane bridge:
    widths, lane orders, APB register map, reset values and symbol types
*/

package dp_bridge_pkg;

    // Link geometry
    localparam int LANES = 4;
    localparam int SPL   = 2;   // Symbols per lane per clock

    // PIO widths
    localparam int PIO_OUT_W = 8;
    localparam int PIO_IN_W  = 7;

    // APB bus
    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;

    // Source lane per destination lane
    localparam int TX_LANE_ORDER [LANES] = '{1, 0, 2, 3};   // PHY lane i <- DP lane
    localparam int RX_LANE_ORDER [LANES] = '{3, 2, 0, 1};   // DP lane i <- PHY lane

    // Register map
    localparam logic [APB_ADDR_W-1:0] REG_CTRL    = 8'h00;
    localparam logic [APB_ADDR_W-1:0] REG_STATUS  = 8'h04;
    localparam logic [APB_ADDR_W-1:0] REG_VERSION = 8'h08;

    // Resets asserted, PLL powered down, clock select 0
    localparam logic [PIO_OUT_W-1:0] CTRL_RESET = 8'hFE;
    localparam int CTRL_TX_DRST_BIT = 5;
    localparam int CTRL_RX_DRST_BIT = 7;

    localparam logic [7:0] VERSION_MAJOR = 8'd1;
    localparam logic [7:0] VERSION_MINOR = 8'd0;

    localparam int unsigned RST_CYCLES        = 1024;
    localparam int unsigned HB_CYCLES_DEFAULT = 25_000_000;

    typedef struct packed {
        logic       disp_ctl;   // 0 automatic, 1 forced
        logic       disp_val;   // 0 negative, 1 positive
        logic       k;          // K character
        logic [7:0] data;
    } tx_sym_t;

    typedef struct packed {
        logic       k;
        logic [7:0] data;
    } rx_sym_t;

    typedef tx_sym_t [SPL-1:0] tx_lane_t;
    typedef rx_sym_t [SPL-1:0] rx_lane_t;

endpackage

/* src/dp_heartbeat.sv */
/*
    Heartbeat LED
    Toggles once every BEAT_CYCLES clocks
*/

`timescale 1ns/1ps

module dp_heartbeat import dp_bridge_pkg::*;
#(
    parameter int unsigned BEAT_CYCLES = HB_CYCLES_DEFAULT
)
(
    input  logic CLK_IN,
    input  logic sys_rst_n,
    output logic led
);

    localparam int CNT_W = $clog2(BEAT_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_WRAP = CNT_W'(BEAT_CYCLES - 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge CLK_IN or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            cnt <= '0;
            led <= 1'b0;
        end
        else if (cnt == CNT_WRAP)
        begin
            cnt <= '0;
            led <= ~led;        // One beat
        end
        else
            cnt <= cnt + 1'b1;
    end

endmodule

/* src/dp_lane_bridge_top.sv */
/*
    DP lane bridge top level
    Reset sequencer, APB PIO registers, TX and RX lane reorder, heartbeat
*/

`timescale 1ns/1ps

module dp_lane_bridge_top import dp_bridge_pkg::*;
#(
    parameter int unsigned HB_CYCLES = HB_CYCLES_DEFAULT
)
(
    input  logic                  CLK_IN,
    input  logic                  arst_n,
    input  logic                  pll_lock,

    // Host APB
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [APB_DATA_W-1:0] pwdata,
    output logic [APB_DATA_W-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,

    // PHY control and status
    input  logic [PIO_IN_W-1:0]   phy_status,
    output logic [PIO_OUT_W-1:0]  phy_ctrl,

    // Link lanes
    input  tx_lane_t              dptx_lanes   [LANES],
    output tx_lane_t              phy_tx_lanes [LANES],
    input  rx_lane_t              phy_rx_lanes [LANES],
    output rx_lane_t              dprx_lanes   [LANES],

    output logic [1:0]            LED_OUT
);

    logic sys_rst_n;

    dp_apb_if apb_if ();

    // Host request into the bus
    assign apb_if.psel    = psel;
    assign apb_if.penable = penable;
    assign apb_if.pwrite  = pwrite;
    assign apb_if.paddr   = paddr;
    assign apb_if.pwdata  = pwdata;

    assign prdata  = apb_if.prdata;
    assign pready  = apb_if.pready;
    assign pslverr = apb_if.pslverr;

    dp_reset_gen reset_gen_inst
    (
        .CLK_IN    (CLK_IN),
        .arst_n    (arst_n),
        .pll_lock  (pll_lock),
        .sys_rst_n (sys_rst_n),
        .sys_ready (LED_OUT[1])     // System ready LED
    );

    dp_pio_regs pio_regs_inst
    (
        .CLK_IN     (CLK_IN),
        .sys_rst_n  (sys_rst_n),
        .apb        (apb_if.slave),
        .phy_status (phy_status),
        .phy_ctrl   (phy_ctrl)
    );

    // DP lanes to PHY lanes
    dp_lane_map #(
        .sym_lane_t (tx_lane_t),
        .ORDER      (TX_LANE_ORDER)
    ) tx_map_inst (
        .CLK_IN    (CLK_IN),
        .sys_rst_n (sys_rst_n),
        .clear     (phy_ctrl[CTRL_TX_DRST_BIT]),
        .lanes_in  (dptx_lanes),
        .lanes_out (phy_tx_lanes)
    );

    // PHY lanes to DP lanes
    dp_lane_map #(
        .sym_lane_t (rx_lane_t),
        .ORDER      (RX_LANE_ORDER)
    ) rx_map_inst (
        .CLK_IN    (CLK_IN),
        .sys_rst_n (sys_rst_n),
        .clear     (phy_ctrl[CTRL_RX_DRST_BIT]),
        .lanes_in  (phy_rx_lanes),
        .lanes_out (dprx_lanes)
    );

    dp_heartbeat #(
        .BEAT_CYCLES (HB_CYCLES)
    ) heartbeat_inst (
        .CLK_IN    (CLK_IN),
        .sys_rst_n (sys_rst_n),
        .led       (LED_OUT[0])
    );

endmodule

/* src/dp_lane_map.sv */
/*
    Registered lane reorder, one clock latency
    Generic over the per-lane symbol type
*/

`timescale 1ns/1ps

module dp_lane_map import dp_bridge_pkg::*;
#(
    parameter type sym_lane_t = logic,
    parameter int  ORDER [LANES] = '{0, 1, 2, 3}   // Source lane for each output lane
)
(
    input  logic      CLK_IN,
    input  logic      sys_rst_n,
    input  logic      clear,
    input  sym_lane_t lanes_in  [LANES],
    output sym_lane_t lanes_out [LANES]
);

    always_ff @(posedge CLK_IN or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            for (int i = 0; i < LANES; i++)
                lanes_out[i] <= '0;
        end
        else
        begin
            for (int i = 0; i < LANES; i++)
            begin
                if (clear)
                    lanes_out[i] <= '0;     // Held by digital reset
                else
                    lanes_out[i] <= lanes_in[ORDER[i]];
            end
        end
    end

endmodule

/* src/dp_pio_regs.sv */
/*
    PIO register block on APB, zero wait states
    Control (RW), synchronized PHY status (RO) and version (RO)
*/

`timescale 1ns/1ps

module dp_pio_regs import dp_bridge_pkg::*;
(
    input  logic                 CLK_IN,
    input  logic                 sys_rst_n,
    dp_apb_if.slave              apb,
    input  logic [PIO_IN_W-1:0]  phy_status,
    output logic [PIO_OUT_W-1:0] phy_ctrl
);

    logic [PIO_OUT_W-1:0] ctrl_q;
    logic [PIO_IN_W-1:0]  status_meta;
    logic [PIO_IN_W-1:0]  status_sync;
    logic                 access;
    logic                 hit_ctrl;
    logic                 hit_status;
    logic                 hit_version;
    logic                 addr_err;
    logic                 wr_ro_err;

    // Status lines come from the PHY clock domains
    always_ff @(posedge CLK_IN)
    begin
        status_meta <= phy_status;
        status_sync <= status_meta;
    end

    assign access      = apb.psel & apb.penable;   // Access phase
    assign hit_ctrl    = (apb.paddr == REG_CTRL);
    assign hit_status  = (apb.paddr == REG_STATUS);
    assign hit_version = (apb.paddr == REG_VERSION);

    assign addr_err  = ~(hit_ctrl | hit_status | hit_version);
    assign wr_ro_err = apb.pwrite & (hit_status | hit_version);

    // Control register
    always_ff @(posedge CLK_IN or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
            ctrl_q <= CTRL_RESET;
        else if (access && apb.pwrite && hit_ctrl)
            ctrl_q <= apb.pwdata[PIO_OUT_W-1:0];
    end

    assign phy_ctrl = ctrl_q;

    // Read mux
    always_comb
    begin
        apb.prdata = '0;
        if (hit_ctrl)
            apb.prdata = APB_DATA_W'(ctrl_q);
        else if (hit_status)
            apb.prdata = APB_DATA_W'(status_sync);
        else if (hit_version)
            apb.prdata = APB_DATA_W'({VERSION_MAJOR, VERSION_MINOR});
    end

    assign apb.pready  = 1'b1;     // No wait states
    assign apb.pslverr = access & (addr_err | wr_ro_err);

endmodule

/* src/dp_reset_gen.sv */
/*
    Reset sequencer
    Holds the design in reset until PLL lock has been stable for RST_CYCLES
*/

`timescale 1ns/1ps

module dp_reset_gen import dp_bridge_pkg::*;
(
    input  logic CLK_IN,
    input  logic arst_n,
    input  logic pll_lock,
    output logic sys_rst_n,
    output logic sys_ready
);

    localparam int CNT_W = $clog2(RST_CYCLES);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(RST_CYCLES - 1);

    logic             lock_rst_n;   // Board reset or lock lost
    logic [CNT_W-1:0] cnt;
    logic             ready_q;

    assign lock_rst_n = arst_n & pll_lock;

    always_ff @(posedge CLK_IN or negedge lock_rst_n)
    begin
        if (!lock_rst_n)
        begin
            cnt     <= '0;
            ready_q <= 1'b0;
        end
        else if (!ready_q)
        begin
            if (cnt == CNT_MAX)
                ready_q <= 1'b1;    // Lock stable long enough
            else
                cnt <= cnt + 1'b1;
        end
    end

    assign sys_rst_n = ready_q;
    assign sys_ready = ready_q;

endmodule
